//--- hdl/dws_settings.svh
// Global widths and limits for the AXI write downsizer
//   Slave and master data widths with derived strobe widths
//   Address, ID and user widths
//   Narrow burst beat limit

`ifndef DWS_SETTINGS_SVH
`define DWS_SETTINGS_SVH

// Wide slave port data bus
`define DWS_SLV_DATA_W 64

// Narrow master port data bus
`define DWS_MST_DATA_W 16

// One strobe bit per data byte
`define DWS_SLV_STRB_W (`DWS_SLV_DATA_W / 8)
`define DWS_MST_STRB_W (`DWS_MST_DATA_W / 8)

// Address and sideband widths
`define DWS_ADDR_W 32
`define DWS_ID_W 4
`define DWS_USER_W 2

// Longest narrow burst the master port may carry
`define DWS_MAX_BEATS 256

`endif

//--- hdl/dws_axi_pkg.sv
// AXI channel types for the write downsizer
//   Field types for id, address, length, size, burst, cache, prot, resp, user
//   Burst and cache encodings
//   AW, wide W, narrow W and B payload structs

package dws_axi_pkg;

  `include "dws_settings.svh"

  typedef logic [`DWS_ID_W-1:0]   id_t;
  typedef logic [`DWS_ADDR_W-1:0] addr_t;
  typedef logic [7:0]             len_t;
  typedef logic [2:0]             size_t;
  typedef logic [1:0]             burst_t;
  typedef logic [3:0]             cache_t;
  typedef logic [2:0]             prot_t;
  typedef logic [1:0]             resp_t;
  typedef logic [`DWS_USER_W-1:0] user_t;

  // Burst types
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  // Cache bit 1 allows the interconnect to reshape the burst
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
    prot_t  prot;
    user_t  user;
  } aw_chan_t;

  typedef struct packed {
    logic [`DWS_SLV_DATA_W-1:0] data;
    logic [`DWS_SLV_STRB_W-1:0] strb;
    logic                       last;
    user_t                      user;
  } slv_w_chan_t;

  typedef struct packed {
    logic [`DWS_MST_DATA_W-1:0] data;
    logic [`DWS_MST_STRB_W-1:0] strb;
    logic                       last;
    user_t                      user;
  } mst_w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
    user_t user;
  } b_chan_t;

endpackage

//--- hdl/dws_plan_pkg.sv
// Internal types shared by the burst planner and the W serializer
//   Narrow beat counter type
//   Write mode enum
//   Burst plan struct

package dws_plan_pkg;

  `include "dws_settings.svh"

  import dws_axi_pkg::*;

  // Remaining narrow beats, zero marks the last beat
  typedef logic [$clog2(`DWS_MAX_BEATS)-1:0] beat_cnt_t;

  typedef enum logic {
    WR_PASSTHROUGH,
    WR_DOWNSIZE
  } wr_mode_t;

  // Everything the serializer needs to walk one burst
  typedef struct packed {
    wr_mode_t  mode;
    addr_t     addr;
    // Beat size of the incoming wide burst
    size_t     slv_size;
    // Beat size issued on the master port
    size_t     mst_size;
    beat_cnt_t beats_left;
  } burst_plan_t;

endpackage

//--- hdl/dws_reg_slice.sv
// Two-entry valid/ready register slice
//   Main output register plus a skid entry
//   Ready toward the source comes from a flop

`timescale 1ns/1ps

module dws_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  logic     main_valid_q;
  logic     skid_valid_q;
  payload_t main_q;
  payload_t skid_q;
  logic     main_load;

  assign in_ready_o  = ~skid_valid_q;
  assign out_o       = main_q;
  assign out_valid_o = main_valid_q;

  // Main register free or draining this cycle
  assign main_load = ~main_valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_load) begin
      main_valid_q <= skid_valid_q | in_valid_i;
      skid_valid_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_load) begin
      main_q <= skid_valid_q ? skid_q : in_i;
    end else if (in_valid_i && in_ready_o) begin
      skid_q <= in_i;
    end
  end

endmodule

//--- hdl/dws_burst_planner.sv
// Write burst planner
//   Accepts slave AW into a one-deep register
//   Computes narrow size and length for modifiable INCR bursts
//   Issues the master AW, then the burst plan for the serializer

`timescale 1ns/1ps

`include "dws_settings.svh"

module dws_burst_planner
  import dws_axi_pkg::*;
  import dws_plan_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  aw_chan_t    slv_aw_i,
  input  logic        slv_aw_valid_i,
  output logic        slv_aw_ready_o,
  output aw_chan_t    mst_aw_o,
  output logic        mst_aw_valid_o,
  input  logic        mst_aw_ready_i,
  output burst_plan_t plan_o,
  output logic        plan_valid_o,
  input  logic        plan_ready_i
);

  localparam int unsigned MstBytes = `DWS_MST_DATA_W / 8;
  localparam int unsigned MstSize  = $clog2(MstBytes);

  // Wide enough for 256 beats times the largest ratio
  typedef logic [10:0] calc_t;

  logic        aw_pend_q, aw_pend_d;
  logic        plan_pend_q, plan_pend_d;
  logic        aw_ready_q;
  aw_chan_t    aw_q, aw_d;
  burst_plan_t plan_q, plan_d;

  logic        slv_aw_hs;
  logic        downsize;
  addr_t       size_mask;
  calc_t       conv_ratio;
  calc_t       align_adj;
  calc_t       new_len;

  assign slv_aw_ready_o = aw_ready_q;
  assign slv_aw_hs      = slv_aw_valid_i & aw_ready_q;

  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_pend_q;

  // Plan waits until its AW has left for the master side
  assign plan_o         = plan_q;
  assign plan_valid_o   = plan_pend_q & ~aw_pend_q;

  // Narrow burst arithmetic on the incoming AW
  assign downsize   = (slv_aw_i.burst == BURST_INCR) &&
                      (|(slv_aw_i.cache & CACHE_MODIFIABLE)) &&
                      (slv_aw_i.size > size_t'(MstSize));
  assign size_mask  = (addr_t'(1) << slv_aw_i.size) - addr_t'(1);
  assign conv_ratio = (calc_t'(1) << slv_aw_i.size) >> MstSize;
  assign align_adj  = calc_t'((slv_aw_i.addr & size_mask) >> MstSize);
  assign new_len    = (calc_t'(slv_aw_i.len) + calc_t'(1)) * conv_ratio
                      - align_adj - calc_t'(1);

  always_comb begin
    aw_d = slv_aw_i;

    plan_d.mode       = WR_PASSTHROUGH;
    plan_d.addr       = slv_aw_i.addr;
    plan_d.slv_size   = slv_aw_i.size;
    plan_d.mst_size   = slv_aw_i.size;
    plan_d.beats_left = beat_cnt_t'(slv_aw_i.len);

    if (downsize) begin
      aw_d.size         = size_t'(MstSize);
      aw_d.len          = len_t'(new_len);
      plan_d.mode       = WR_DOWNSIZE;
      plan_d.mst_size   = size_t'(MstSize);
      plan_d.beats_left = beat_cnt_t'(new_len);
    end
  end

  // Each half of the register drains on its own handshake
  assign aw_pend_d   = slv_aw_hs | (aw_pend_q & ~mst_aw_ready_i);
  assign plan_pend_d = slv_aw_hs | (plan_pend_q & ~(plan_valid_o & plan_ready_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_pend_q   <= 1'b0;
      plan_pend_q <= 1'b0;
      aw_ready_q  <= 1'b0;
    end else begin
      aw_pend_q   <= aw_pend_d;
      plan_pend_q <= plan_pend_d;
      // Open again once both the AW and the plan are gone
      aw_ready_q  <= ~(aw_pend_d | plan_pend_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv_aw_hs) begin
      aw_q   <= aw_d;
      plan_q <= plan_d;
    end
  end

endmodule

//--- hdl/dws_w_serializer.sv
// Write data serializer
//   Loads one burst plan at a time while idle
//   Steers bytes and strobes of each wide W beat onto narrow lanes
//   Releases the wide beat once its last byte has gone out

`timescale 1ns/1ps

`include "dws_settings.svh"

module dws_w_serializer
  import dws_axi_pkg::*;
  import dws_plan_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  burst_plan_t plan_i,
  input  logic        plan_valid_i,
  output logic        plan_ready_o,
  input  slv_w_chan_t slv_w_i,
  input  logic        slv_w_valid_i,
  output logic        slv_w_ready_o,
  output mst_w_chan_t mst_w_o,
  output logic        mst_w_valid_o,
  input  logic        mst_w_ready_i
);

  localparam int unsigned SlvBytes = `DWS_SLV_DATA_W / 8;
  localparam int unsigned MstBytes = `DWS_MST_DATA_W / 8;
  localparam int unsigned SlvOffW  = $clog2(SlvBytes);

  logic        active_q;
  burst_plan_t plan_q;

  logic        mst_w_hs;
  logic        last_beat;
  logic        word_done;
  addr_t       mst_mask;
  addr_t       slv_mask;
  addr_t       next_addr;

  assign plan_ready_o  = ~active_q;
  assign mst_w_valid_o = active_q & slv_w_valid_i;
  assign mst_w_hs      = mst_w_valid_o & mst_w_ready_i;
  assign last_beat     = (plan_q.beats_left == '0);

  // Next size-aligned address on the master side
  assign mst_mask  = (addr_t'(1) << plan_q.mst_size) - addr_t'(1);
  assign slv_mask  = (addr_t'(1) << plan_q.slv_size) - addr_t'(1);
  assign next_addr = (plan_q.addr & ~mst_mask) + (addr_t'(1) << plan_q.mst_size);

  // Crossing into the next wide word
  assign word_done = (next_addr & ~slv_mask) != (plan_q.addr & ~slv_mask);

  assign slv_w_ready_o = mst_w_hs &
                         ((plan_q.mode == WR_PASSTHROUGH) | last_beat | word_done);

  // Lane steering
  always_comb begin
    int unsigned slv_off;
    int unsigned base;
    int unsigned lane;
    int unsigned beat_bytes;

    slv_off    = int'(plan_q.addr[SlvOffW-1:0]);
    base       = slv_off - (slv_off % MstBytes);
    beat_bytes = 1 << plan_q.mst_size;

    mst_w_o      = '0;
    mst_w_o.last = last_beat;
    mst_w_o.user = slv_w_i.user;

    for (int m = 0; m < MstBytes; m++) begin
      lane = base + m;
      if ((lane >= slv_off) && (lane - slv_off < beat_bytes)) begin
        mst_w_o.data[8*m +: 8] = slv_w_i.data[8*lane +: 8];
        mst_w_o.strb[m]        = slv_w_i.strb[lane];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
    end else if (!active_q) begin
      active_q <= plan_valid_i;
    end else if (mst_w_hs && last_beat) begin
      active_q <= 1'b0;
    end
  end

  // Walks address and count through the burst
  always_ff @(posedge clk_i) begin
    if (!active_q && plan_valid_i) begin
      plan_q <= plan_i;
    end else if (mst_w_hs) begin
      plan_q.addr       <= next_addr;
      plan_q.beats_left <= plan_q.beats_left - beat_cnt_t'(1);
    end
  end

endmodule

//--- hdl/axi_dw_downsizer.sv
// AXI write data width downsizer, wide slave port to narrow master port
//   Burst planner on slave AW
//   W serializer between slave W and master W
//   Register slices on master AW and W
//   Direct B response path

`timescale 1ns/1ps

module axi_dw_downsizer
  import dws_axi_pkg::*;
  import dws_plan_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Slave port
  input  aw_chan_t    slv_aw_i,
  input  logic        slv_aw_valid_i,
  output logic        slv_aw_ready_o,
  input  slv_w_chan_t slv_w_i,
  input  logic        slv_w_valid_i,
  output logic        slv_w_ready_o,
  output b_chan_t     slv_b_o,
  output logic        slv_b_valid_o,
  input  logic        slv_b_ready_i,
  // Master port
  output aw_chan_t    mst_aw_o,
  output logic        mst_aw_valid_o,
  input  logic        mst_aw_ready_i,
  output mst_w_chan_t mst_w_o,
  output logic        mst_w_valid_o,
  input  logic        mst_w_ready_i,
  input  b_chan_t     mst_b_i,
  input  logic        mst_b_valid_i,
  output logic        mst_b_ready_o
);

  aw_chan_t    plan_aw;
  logic        plan_aw_valid, plan_aw_ready;
  burst_plan_t plan;
  logic        plan_valid, plan_ready;
  mst_w_chan_t ser_w;
  logic        ser_w_valid, ser_w_ready;

  dws_burst_planner i_planner (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_o       (plan_aw),
    .mst_aw_valid_o (plan_aw_valid),
    .mst_aw_ready_i (plan_aw_ready),
    .plan_o         (plan),
    .plan_valid_o   (plan_valid),
    .plan_ready_i   (plan_ready)
  );

  dws_w_serializer i_serializer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .plan_i        (plan),
    .plan_valid_i  (plan_valid),
    .plan_ready_o  (plan_ready),
    .slv_w_i       (slv_w_i),
    .slv_w_valid_i (slv_w_valid_i),
    .slv_w_ready_o (slv_w_ready_o),
    .mst_w_o       (ser_w),
    .mst_w_valid_o (ser_w_valid),
    .mst_w_ready_i (ser_w_ready)
  );

  dws_reg_slice #(.payload_t(aw_chan_t)) i_aw_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_i        (plan_aw),
    .in_valid_i  (plan_aw_valid),
    .in_ready_o  (plan_aw_ready),
    .out_o       (mst_aw_o),
    .out_valid_o (mst_aw_valid_o),
    .out_ready_i (mst_aw_ready_i)
  );

  dws_reg_slice #(.payload_t(mst_w_chan_t)) i_w_slice (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_i        (ser_w),
    .in_valid_i  (ser_w_valid),
    .in_ready_o  (ser_w_ready),
    .out_o       (mst_w_o),
    .out_valid_o (mst_w_valid_o),
    .out_ready_i (mst_w_ready_i)
  );

  // Responses need no conversion
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

//--- verification/dws_checker.sv
// Scoreboard for the AXI write downsizer
//   Expected queues for master AW, master W and slave B
//   Compares every handshake with the queue head
//   Counts matches and errors, reports leftover expectations

`timescale 1ns/1ps

module dws_checker
  import dws_axi_pkg::*;
  import dws_plan_pkg::*;
(
  input  logic        clk_i,
  input  aw_chan_t    mst_aw_i,
  input  logic        mst_aw_valid_i,
  input  logic        mst_aw_ready_i,
  input  mst_w_chan_t mst_w_i,
  input  logic        mst_w_valid_i,
  input  logic        mst_w_ready_i,
  input  b_chan_t     slv_b_i,
  input  logic        slv_b_valid_i,
  input  logic        slv_b_ready_i,
  input  logic        done_i,
  output int          err_cnt_o,
  output int          match_cnt_o,
  output logic        idle_o
);

  aw_chan_t    exp_aw_q[$];
  mst_w_chan_t exp_w_q[$];
  b_chan_t     exp_b_q[$];
  int          w_seen;
  logic        done_seen;

  initial begin
    err_cnt_o   = 0;
    match_cnt_o = 0;
    idle_o      = 1'b1;
    w_seen      = 0;
    done_seen   = 1'b0;
  end

  // Sample mid-cycle where valid and ready are settled
  always @(negedge clk_i) begin
    aw_chan_t    exp_aw;
    mst_w_chan_t exp_w;
    b_chan_t     exp_b;

    if (mst_aw_valid_i && mst_aw_ready_i) begin
      if (exp_aw_q.size() == 0) begin
        $display("Unexpected master AW at %0t ns while no burst was outstanding", $time);
        err_cnt_o++;
      end else begin
        exp_aw = exp_aw_q.pop_front();
        if (mst_aw_i !== exp_aw) begin
          $display("Error %0t ns: master AW got %h, expected %h", $time, mst_aw_i, exp_aw);
          err_cnt_o++;
        end else begin
          match_cnt_o++;
        end
      end
    end

    if (mst_w_valid_i && mst_w_ready_i) begin
      if (exp_w_q.size() == 0) begin
        $display("Unexpected master W beat at %0t ns after all expected beats", $time);
        err_cnt_o++;
      end else begin
        exp_w = exp_w_q.pop_front();
        if (mst_w_i !== exp_w) begin
          $display("Error %0t ns: W beat %0d got %h %b %b, expected %h %b %b",
                   $time, w_seen, mst_w_i.data, mst_w_i.strb, mst_w_i.last,
                   exp_w.data, exp_w.strb, exp_w.last);
          err_cnt_o++;
        end else begin
          match_cnt_o++;
        end
      end
      w_seen++;
    end

    if (slv_b_valid_i && slv_b_ready_i) begin
      if (exp_b_q.size() == 0) begin
        $display("Unexpected slave B at %0t ns with no response outstanding", $time);
        err_cnt_o++;
      end else begin
        exp_b = exp_b_q.pop_front();
        if (slv_b_i !== exp_b) begin
          $display("Error %0t ns: slave B got %h, expected %h", $time, slv_b_i, exp_b);
          err_cnt_o++;
        end else begin
          match_cnt_o++;
        end
      end
    end

    // Anything still queued at the end never showed up
    if (done_i && !done_seen) begin
      done_seen = 1'b1;
      if (exp_aw_q.size() + exp_w_q.size() + exp_b_q.size() != 0) begin
        $display("Traffic missing at the end: %0d AW, %0d W beats, %0d B still expected",
                 exp_aw_q.size(), exp_w_q.size(), exp_b_q.size());
        err_cnt_o++;
      end
    end

    idle_o = (exp_aw_q.size() == 0) && (exp_w_q.size() == 0) && (exp_b_q.size() == 0);
  end

endmodule

//--- verification/tb_axi_dw_downsizer.sv
// Testbench for the AXI write downsizer
//   Clock, reset, random master ready and B stimulus
//   Reference model for the narrow AW and W beat stream
//   Test sequence, timeout and final verdict

`timescale 1ns/1ps

module tb_axi_dw_downsizer
  import dws_axi_pkg::*;
();

  logic        clk_i, rst_ni, done;
  aw_chan_t    slv_aw, mst_aw;
  slv_w_chan_t slv_w;
  mst_w_chan_t mst_w;
  b_chan_t     slv_b, mst_b;
  logic        slv_aw_valid, slv_aw_ready, slv_w_valid, slv_w_ready;
  logic        slv_b_valid, slv_b_ready, mst_aw_valid, mst_aw_ready;
  logic        mst_w_valid, mst_w_ready, mst_b_valid, mst_b_ready;
  logic        chk_idle, bp_en;
  int          err_cnt, match_cnt, cycle_cnt, cycle_limit, beats_total, test_num;
  int          reset_err;
  integer      seed;
  aw_chan_t    aw_q[$];
  slv_w_chan_t w_q[$];

  axi_dw_downsizer i_dut (
    .clk_i, .rst_ni,
    .slv_aw_i (slv_aw), .slv_aw_valid_i (slv_aw_valid), .slv_aw_ready_o (slv_aw_ready),
    .slv_w_i  (slv_w),  .slv_w_valid_i  (slv_w_valid),  .slv_w_ready_o  (slv_w_ready),
    .slv_b_o  (slv_b),  .slv_b_valid_o  (slv_b_valid),  .slv_b_ready_i  (slv_b_ready),
    .mst_aw_o (mst_aw), .mst_aw_valid_o (mst_aw_valid), .mst_aw_ready_i (mst_aw_ready),
    .mst_w_o  (mst_w),  .mst_w_valid_o  (mst_w_valid),  .mst_w_ready_i  (mst_w_ready),
    .mst_b_i  (mst_b),  .mst_b_valid_i  (mst_b_valid),  .mst_b_ready_o  (mst_b_ready)
  );

  dws_checker i_checker (
    .clk_i,
    .mst_aw_i (mst_aw), .mst_aw_valid_i (mst_aw_valid), .mst_aw_ready_i (mst_aw_ready),
    .mst_w_i  (mst_w),  .mst_w_valid_i  (mst_w_valid),  .mst_w_ready_i  (mst_w_ready),
    .slv_b_i  (slv_b),  .slv_b_valid_i  (slv_b_valid),  .slv_b_ready_i  (slv_b_ready),
    .done_i   (done),   .err_cnt_o (err_cnt), .match_cnt_o (match_cnt), .idle_o (chk_idle)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Master side ready is random while back-pressure is on
  // Slave B ready is random throughout
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      mst_aw_ready = !bp_en || (($random(seed) & 3) != 0);
      mst_w_ready  = !bp_en || (($random(seed) & 3) != 0);
      slv_b_ready  = (($random(seed) & 3) != 0);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped moving traffic", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Expected master AW and narrow W beats for one slave burst
  function automatic int expect_burst(input aw_chan_t aw, input slv_w_chan_t wide[$]);
    aw_chan_t    exp_aw;
    mst_w_chan_t nb;
    bit          shrink;
    int unsigned step, n, wi, off, lane;
    logic [31:0] a, nxt;

    shrink = (aw.burst == BURST_INCR) && aw.cache[1] && (aw.size > 3'd1);
    exp_aw = aw;
    n      = int'(aw.len) + 1;
    step   = 1 << aw.size;
    if (shrink) begin
      // Two bytes per narrow beat minus the bytes skipped before the start address
      n           = n * (step / 2) - (aw.addr % step) / 2;
      step        = 2;
      exp_aw.size = 3'd1;
      exp_aw.len  = 8'(n - 1);
    end
    i_checker.exp_aw_q.push_back(exp_aw);
    a  = aw.addr;
    wi = 0;
    for (int k = 0; k < int'(n); k++) begin
      off = a % 8;
      nb  = '0;
      for (int m = 0; m < 2; m++) begin
        lane = (off / 2) * 2 + m;
        if (lane >= off && lane < off + step) begin
          nb.data[8*m +: 8] = wide[wi].data[8*lane +: 8];
          nb.strb[m]        = wide[wi].strb[lane];
        end
      end
      nb.last = (k == int'(n) - 1);
      nb.user = wide[wi].user;
      i_checker.exp_w_q.push_back(nb);
      nxt = (a / step) * step + step;
      if (!shrink || (nxt >> aw.size) != (a >> aw.size)) wi++;
      a = nxt;
    end
    return n;
  endfunction

  function automatic aw_chan_t make_aw(input addr_t addr, input len_t len, input size_t size,
                                       input burst_t burst, input cache_t cache);
    aw_chan_t aw;

    aw.id    = id_t'($random(seed));
    aw.addr  = addr;
    aw.len   = len;
    aw.size  = size;
    aw.burst = burst;
    aw.cache = cache;
    aw.prot  = prot_t'($random(seed));
    aw.user  = user_t'($random(seed));
    return aw;
  endfunction

  // Random wide beats of one burst go to the driver queue
  task automatic add_burst(input aw_chan_t aw);
    slv_w_chan_t wide[$];
    slv_w_chan_t beat;

    for (int i = 0; i <= int'(aw.len); i++) begin
      beat.data = {$random(seed), $random(seed)};
      beat.strb = 8'($random(seed));
      beat.last = (i == int'(aw.len));
      beat.user = user_t'($random(seed));
      wide.push_back(beat);
      w_q.push_back(beat);
    end
    aw_q.push_back(aw);
    beats_total += expect_burst(aw, wide);
    cycle_limit  = 200 + 4 * beats_total;
  endtask

  task automatic send_aw();
    while (aw_q.size() > 0) begin
      slv_aw       = aw_q.pop_front();
      slv_aw_valid = 1'b1;
      @(negedge clk_i);
      while (!slv_aw_ready) @(negedge clk_i);
      @(posedge clk_i);
      #1;
    end
    slv_aw_valid = 1'b0;
  endtask

  task automatic send_w();
    while (w_q.size() > 0) begin
      slv_w       = w_q.pop_front();
      slv_w_valid = 1'b1;
      @(negedge clk_i);
      while (!slv_w_ready) @(negedge clk_i);
      @(posedge clk_i);
      #1;
    end
    slv_w_valid = 1'b0;
  endtask

  task automatic finish_test(input string name);
    @(posedge clk_i);
    while (!chk_idle) @(posedge clk_i);
    #1;
    test_num++;
    $display("Test %0d %s finished, errors so far %0d", test_num, name,
             err_cnt + reset_err);
  endtask

  task automatic run_traffic(input string name);
    fork
      send_aw();
      send_w();
    join
    finish_test(name);
  endtask

  task automatic run_responses(input int count);
    b_chan_t b;
    int      gap;

    beats_total += count;
    cycle_limit  = 200 + 4 * beats_total;
    for (int i = 0; i < count; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) begin
        @(posedge clk_i);
        #1;
      end
      b.id   = id_t'($random(seed));
      b.resp = resp_t'($random(seed));
      b.user = user_t'($random(seed));
      i_checker.exp_b_q.push_back(b);
      mst_b       = b;
      mst_b_valid = 1'b1;
      @(negedge clk_i);
      while (!mst_b_ready) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      mst_b_valid = 1'b0;
    end
    finish_test("B responses");
  endtask

  initial begin
    seed         = 20185;
    cycle_cnt    = 0;
    cycle_limit  = 200;
    beats_total  = 0;
    test_num     = 0;
    reset_err    = 0;
    bp_en        = 1'b0;
    done         = 1'b0;
    rst_ni       = 1'b0;
    slv_aw       = '0;
    slv_aw_valid = 1'b0;
    slv_w        = '0;
    slv_w_valid  = 1'b0;
    slv_b_ready  = 1'b1;
    mst_aw_ready = 1'b1;
    mst_w_ready  = 1'b1;
    mst_b        = '0;
    mst_b_valid  = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    // Handshake outputs stay low while reset is held
    if (slv_aw_ready || slv_w_ready || mst_aw_valid || mst_w_valid) begin
      $display("Error %0t ns: handshake outputs not low during reset", $time);
      reset_err++;
    end
    rst_ni = 1'b1;

    add_burst(make_aw(32'h1000, 8'd3, 3'd3, BURST_INCR, CACHE_MODIFIABLE));
    run_traffic("aligned downsize");

    add_burst(make_aw(32'h2006, 8'd1, 3'd3, BURST_INCR, CACHE_MODIFIABLE));
    add_burst(make_aw(32'h2013, 8'd2, 3'd2, BURST_INCR, CACHE_MODIFIABLE));
    run_traffic("unaligned start");

    add_burst(make_aw(32'h3002, 8'd3, 3'd1, BURST_FIXED, CACHE_MODIFIABLE));
    add_burst(make_aw(32'h3010, 8'd2, 3'd1, BURST_INCR, 4'b0000));
    add_burst(make_aw(32'h3004, 8'd3, 3'd1, BURST_INCR, CACHE_MODIFIABLE));
    run_traffic("pass-through");

    run_responses(8);

    // Back-to-back AWs while earlier bursts still serialize
    bp_en = 1'b1;
    add_burst(make_aw(32'h4000, 8'd7, 3'd3, BURST_INCR, CACHE_MODIFIABLE));
    add_burst(make_aw(32'h4102, 8'd3, 3'd2, BURST_INCR, CACHE_MODIFIABLE));
    add_burst(make_aw(32'h4200, 8'd4, 3'd1, BURST_INCR, CACHE_MODIFIABLE));
    add_burst(make_aw(32'h4301, 8'd3, 3'd0, BURST_FIXED, CACHE_MODIFIABLE));
    add_burst(make_aw(32'h4404, 8'd15, 3'd3, BURST_INCR, 4'b0011));
    run_traffic("back-pressure pipelined");
    bp_en = 1'b0;

    done = 1'b1;
    repeat (2) @(posedge clk_i);
    $display("Tests %0d, checks passed %0d, errors %0d", test_num, match_cnt,
             err_cnt + reset_err);
    if (err_cnt + reset_err == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- axi_dw_downsizer.f
+incdir+hdl
hdl/dws_axi_pkg.sv
hdl/dws_plan_pkg.sv
hdl/dws_reg_slice.sv
hdl/dws_burst_planner.sv
hdl/dws_w_serializer.sv
hdl/axi_dw_downsizer.sv
verification/dws_checker.sv
verification/tb_axi_dw_downsizer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the downsizer testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f axi_dw_downsizer.f \
  --top-module tb_axi_dw_downsizer -Mdir obj_dir \
  && ./obj_dir/Vtb_axi_dw_downsizer > sim.log \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
